// File: compile.f
+incdir+tb
logic/wbuf_pkg.sv
logic/wb_line_if.sv
logic/lutram_1w_mr.sv
logic/dcache_fifo.sv
logic/line_writeback_engine.sv
logic/dcache_wbuf_top.sv
tb/tb_dcache_wbuf.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_dcache_wbuf
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb/tb_checks.svh
// flags such as hits, full, empty and memory valid
task automatic check_hit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
        stop_with_failure($sformatf("** Error @ %0t: %s is %b, expected %b",
            $time, what, got, exp));
    end
endtask

// whole cache line, compared flat
task automatic check_line(input string what, input dcache_line_u got,
                          input dcache_line_u exp);
    if (got.flat !== exp.flat) begin
        stop_with_failure($sformatf("** Error @ %0t: %s is %h, expected %h",
            $time, what, got.flat, exp.flat));
    end
endtask

// one memory beat, address and data
task automatic check_word(input logic [ADDR_WIDTH-1:0] got_addr,
                          input logic [WORD_WIDTH-1:0] got_data,
                          input logic [ADDR_WIDTH-1:0] exp_addr,
                          input logic [WORD_WIDTH-1:0] exp_data);
    if (got_addr !== exp_addr) begin
        stop_with_failure($sformatf("** Error @ %0t: beat address %h, expected %h",
            $time, got_addr, exp_addr));
    end
    if (got_data !== exp_data) begin
        stop_with_failure($sformatf("** Error @ %0t: beat data %h at %h, expected %h",
            $time, got_data, got_addr, exp_data));
    end
endtask

// galois lfsr, taps for x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic [15:0] nxt;
    nxt = state >> 1;
    if (state[0]) begin
        nxt = nxt ^ 16'hB400;
    end
    return nxt;
endfunction

// File: tb/tb_dcache_wbuf.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dcache_wbuf
    import wbuf_pkg::*;
();

    localparam int DEPTH = 4;
    localparam int DRAIN_LIMIT = 400;

    typedef enum logic [1:0] {WR, RD, IDLE, DRAIN} kind_e;

    // one table row, lines given by pattern number
    typedef struct {
        kind_e kind;
        logic [ADDR_WIDTH-1:0] addr;
        int line_id;
        logic exp_hit;
        int exp_id;
    } step_t;

    logic clk;
    logic rst;
    logic cpu_wreq;
    logic [ADDR_WIDTH-1:0] cpu_awaddr;
    dcache_line_u cpu_wdata;
    logic write_hit;
    logic cpu_rreq;
    logic [ADDR_WIDTH-1:0] cpu_araddr;
    logic read_hit;
    dcache_line_u cpu_rdata;
    logic full;
    logic empty;
    logic mem_wvalid;
    logic [ADDR_WIDTH-1:0] mem_waddr;
    logic [WORD_WIDTH-1:0] mem_wdata;
    logic mem_wready;

    step_t steps [$];
    logic [15:0] lfsr;

    // reference queue, line addresses with their latest data
    logic [ADDR_WIDTH-1:0] q_addr [$];
    dcache_line_u q_line [$];
    logic m_busy;
    logic m_hold;
    int m_beats;
    // beats memory should see, in order
    logic [ADDR_WIDTH-1:0] beat_addr [$];
    logic [WORD_WIDTH-1:0] beat_data [$];
    // read issued in the previous cycle
    logic rd_pending;
    logic rd_exp_hit;
    dcache_line_u rd_exp_line;

    dcache_wbuf_top #(
        .DEPTH(DEPTH)
    ) dut_i (
        .clk(clk),
        .rst(rst),
        .cpu_wreq_i(cpu_wreq),
        .cpu_awaddr_i(cpu_awaddr),
        .cpu_wdata_i(cpu_wdata),
        .write_hit_o(write_hit),
        .cpu_rreq_i(cpu_rreq),
        .cpu_araddr_i(cpu_araddr),
        .read_hit_o(read_hit),
        .cpu_rdata_o(cpu_rdata),
        .full_o(full),
        .empty_o(empty),
        .mem_wvalid_o(mem_wvalid),
        .mem_waddr_o(mem_waddr),
        .mem_wdata_o(mem_wdata),
        .mem_wready_i(mem_wready)
    );

    always #4 clk = ~clk;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    `include "tb_checks.svh"

    function automatic logic [ADDR_WIDTH-1:0] line_base(input logic [ADDR_WIDTH-1:0] addr);
        return {addr[ADDR_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    endfunction

    function automatic dcache_line_u pattern_line(input int id);
        dcache_line_u line;
        for (int k = 0; k < WORDS_PER_LINE; k++) begin
            line.words[k] = {16'(id) ^ 16'hA5C3, 16'(k) + 16'h7100};
        end
        return line;
    endfunction

    task automatic add_step(input kind_e kind, input logic [ADDR_WIDTH-1:0] addr,
                            input int line_id, input logic exp_hit, input int exp_id);
        steps.push_back('{kind: kind, addr: addr, line_id: line_id,
                          exp_hit: exp_hit, exp_id: exp_id});
    endtask

    // queue and engine state at the coming clock edge
    task automatic model_edge(input logic wreq, input logic [ADDR_WIDTH-1:0] addr,
                              input dcache_line_u line);
        int hit_idx;
        logic head_hit;
        logic pop;
        hit_idx = -1;
        if (wreq) begin
            foreach (q_addr[i]) begin
                if (q_addr[i] == line_base(addr)) begin
                    hit_idx = i;
                end
            end
        end
        head_hit = (hit_idx == 0);
        pop = !m_busy && (q_addr.size() > 0) && !head_hit && !m_hold;
        if (head_hit) begin
            m_hold = 1'b1;
        end else if (!m_busy) begin
            m_hold = 1'b0;
        end
        if (m_busy && mem_wready) begin
            m_beats++;
            if (m_beats == WORDS_PER_LINE) begin
                m_busy = 1'b0;
            end
        end
        // merge in place, or take a new slot
        if (hit_idx >= 0) begin
            q_line[hit_idx] = line;
        end else if (wreq) begin
            q_addr.push_back(line_base(addr));
            q_line.push_back(line);
        end
        if (pop) begin
            for (int k = 0; k < WORDS_PER_LINE; k++) begin
                beat_addr.push_back(q_addr[0] + ADDR_WIDTH'(k * (WORD_WIDTH / 8)));
                beat_data.push_back(q_line[0].words[k]);
            end
            q_addr.pop_front();
            q_line.pop_front();
            m_busy = 1'b1;
            m_beats = 0;
        end
    endtask

    task automatic check_outputs();
        check_hit("full_o", full, q_addr.size() == DEPTH);
        check_hit("empty_o", empty, q_addr.size() == 0);
        check_hit("mem_wvalid_o", mem_wvalid, m_busy);
        check_hit("read_hit_o", read_hit, rd_pending && rd_exp_hit);
        if (rd_pending && rd_exp_hit) begin
            check_line("cpu_rdata_o", cpu_rdata, rd_exp_line);
        end
        // memory sink
        if (mem_wvalid && mem_wready) begin
            if (beat_addr.size() == 0) begin
                stop_with_failure($sformatf("** Error @ %0t: extra memory beat at %h",
                    $time, mem_waddr));
            end else begin
                check_word(mem_waddr, mem_wdata, beat_addr[0], beat_data[0]);
                beat_addr.pop_front();
                beat_data.pop_front();
            end
        end
    endtask

    task automatic run_cycle(input step_t s);
        dcache_line_u line;
        line = pattern_line(s.line_id);
        @(posedge clk);
        #1;
        cpu_wreq = (s.kind == WR);
        cpu_awaddr = s.addr;
        cpu_wdata = line;
        cpu_rreq = (s.kind == RD);
        cpu_araddr = s.addr;
        lfsr = lfsr_next(lfsr);
        mem_wready = lfsr[0];
        @(negedge clk);
        check_outputs();
        check_hit("write_hit_o", write_hit, (s.kind == WR) && s.exp_hit);
        model_edge(s.kind == WR, s.addr, line);
        rd_pending = (s.kind == RD);
        rd_exp_hit = s.exp_hit;
        rd_exp_line = pattern_line(s.exp_id);
    endtask

    task automatic drain_all();
        step_t idle_step;
        int cycles;
        idle_step = '{kind: IDLE, addr: '0, line_id: 0, exp_hit: 1'b0, exp_id: 0};
        cycles = 0;
        do begin
            run_cycle(idle_step);
            cycles++;
            if (cycles > DRAIN_LIMIT) begin
                stop_with_failure("buffer did not drain to memory in time");
            end
        end while (!(empty && !mem_wvalid));
    endtask

    task automatic build_table();
        // nothing queued after reset
        add_step(RD, 32'h0000_1000, 0, 1'b0, 0);
        add_step(RD, 32'h0000_2008, 0, 1'b0, 0);
        // first miss goes straight to the engine, the next four fill the queue
        add_step(WR, 32'h0000_0100, 1, 1'b0, 0);
        add_step(WR, 32'h0000_0200, 2, 1'b0, 0);
        add_step(WR, 32'h0000_0300, 3, 1'b0, 0);
        add_step(WR, 32'h0000_0400, 4, 1'b0, 0);
        add_step(WR, 32'h0000_0500, 5, 1'b0, 0);
        add_step(WR, 32'h0000_0208, 6, 1'b1, 0);
        add_step(RD, 32'h0000_0304, 0, 1'b1, 3);
        add_step(RD, 32'h0000_020c, 0, 1'b1, 6);
        add_step(RD, 32'h0000_0900, 0, 1'b0, 0);
        add_step(DRAIN, '0, 0, 1'b0, 0);
        // head rewrite with the engine idle
        add_step(WR, 32'h0000_0600, 7, 1'b0, 0);
        add_step(WR, 32'h0000_060c, 8, 1'b1, 0);
        add_step(IDLE, '0, 0, 1'b0, 0);
        add_step(RD, 32'h0000_0600, 0, 1'b1, 8);
        add_step(DRAIN, '0, 0, 1'b0, 0);
        // mixed traffic
        add_step(WR, 32'h0000_1000, 9, 1'b0, 0);
        add_step(WR, 32'h0000_1010, 10, 1'b0, 0);
        add_step(WR, 32'h0000_1014, 11, 1'b1, 0);
        add_step(WR, 32'h0000_1020, 12, 1'b0, 0);
        add_step(RD, 32'h0000_1018, 0, 1'b1, 11);
        add_step(WR, 32'h0000_1030, 13, 1'b0, 0);
        add_step(WR, 32'h0000_1024, 14, 1'b1, 0);
        add_step(WR, 32'h0000_1040, 15, 1'b0, 0);
        add_step(IDLE, '0, 0, 1'b0, 0);
        add_step(RD, 32'h0000_1028, 0, 1'b1, 14);
        add_step(RD, 32'h0000_104c, 0, 1'b1, 15);
        add_step(DRAIN, '0, 0, 1'b0, 0);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        cpu_wreq = 1'b0;
        cpu_awaddr = '0;
        cpu_wdata = '0;
        cpu_rreq = 1'b0;
        cpu_araddr = '0;
        mem_wready = 1'b0;
        lfsr = 16'd95;
        m_busy = 1'b0;
        m_hold = 1'b0;
        m_beats = 0;
        rd_pending = 1'b0;
        rd_exp_hit = 1'b0;
        rd_exp_line = '0;
        build_table();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (steps[i]) begin
            if (steps[i].kind == DRAIN) begin
                drain_all();
            end else begin
                run_cycle(steps[i]);
            end
        end
        if (beat_addr.size() != 0) begin
            stop_with_failure("memory did not receive every queued line");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: logic/dcache_wbuf_top.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_wbuf_top
    import wbuf_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  logic clk,
    input  logic rst,
    // cpu write
    input  logic cpu_wreq_i,
    input  logic [ADDR_WIDTH-1:0] cpu_awaddr_i,
    input  dcache_line_u cpu_wdata_i,
    output logic write_hit_o,
    // cpu read
    input  logic cpu_rreq_i,
    input  logic [ADDR_WIDTH-1:0] cpu_araddr_i,
    output logic read_hit_o,
    output dcache_line_u cpu_rdata_o,
    // status
    output logic full_o,
    output logic empty_o,
    // memory side
    output logic mem_wvalid_o,
    output logic [ADDR_WIDTH-1:0] mem_waddr_o,
    output logic [WORD_WIDTH-1:0] mem_wdata_o,
    input  logic mem_wready_i
);

    wb_line_if wb_if ();

    dcache_fifo #(
        .DEPTH(DEPTH)
    ) u_fifo (
        .clk(clk),
        .rst(rst),
        .cpu_wreq_i(cpu_wreq_i),
        .cpu_awaddr_i(cpu_awaddr_i),
        .cpu_wdata_i(cpu_wdata_i),
        .write_hit_o(write_hit_o),
        .cpu_rreq_i(cpu_rreq_i),
        .cpu_araddr_i(cpu_araddr_i),
        .read_hit_o(read_hit_o),
        .cpu_rdata_o(cpu_rdata_o),
        .full_o(full_o),
        .empty_o(empty_o),
        .wb(wb_if.fifo_mp)
    );

    line_writeback_engine u_engine (
        .clk(clk),
        .rst(rst),
        .wb(wb_if.engine_mp),
        .mem_wvalid_o(mem_wvalid_o),
        .mem_waddr_o(mem_waddr_o),
        .mem_wdata_o(mem_wdata_o),
        .mem_wready_i(mem_wready_i)
    );

endmodule

`default_nettype wire

// File: logic/line_writeback_engine.sv
`timescale 1ns/100ps
`default_nettype none

module line_writeback_engine
    import wbuf_pkg::*;
(
    input  logic clk,
    input  logic rst,
    // line from the buffer
    wb_line_if.engine_mp wb,
    // memory word port
    output logic mem_wvalid_o,
    output logic [ADDR_WIDTH-1:0] mem_waddr_o,
    output logic [WORD_WIDTH-1:0] mem_wdata_o,
    input  logic mem_wready_i
);

    localparam int BEAT_W = $clog2(WORDS_PER_LINE);
    localparam int WORD_BYTES = WORD_WIDTH / 8;
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(WORDS_PER_LINE - 1);

    logic busy_q;
    logic [BEAT_W-1:0] beat_q;
    logic beat_taken;

    // captured line and its address
    dcache_line_u line_q;
    logic [ADDR_WIDTH-1:0] addr_q;

    assign beat_taken = busy_q && mem_wready_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            beat_q <= '0;
        end else if (!busy_q) begin
            if (wb.wen) begin
                busy_q <= 1'b1;
                beat_q <= '0;
            end
        end else if (beat_taken) begin
            beat_q <= beat_q + BEAT_W'(1);
            // done after the last word
            if (beat_q == LAST_BEAT) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wb.wen && !busy_q) begin
            line_q <= wb.wdata;
            addr_q <= wb.awaddr;
        end
    end

    assign wb.idle = !busy_q;

    // word k of the line at line address plus k words
    assign mem_wvalid_o = busy_q;
    assign mem_wdata_o = line_q.words[beat_q];
    assign mem_waddr_o = addr_q + ADDR_WIDTH'(beat_q) * ADDR_WIDTH'(WORD_BYTES);

    // a stalled beat holds address and data
    a_beat_stable: assert property (
        @(posedge clk) disable iff (rst)
        mem_wvalid_o && !mem_wready_i |=>
            mem_wvalid_o && $stable(mem_waddr_o) && $stable(mem_wdata_o)
    ) else $error("memory beat changed before it was taken");

endmodule

`default_nettype wire

// File: logic/dcache_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_fifo
    import wbuf_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  logic clk,
    input  logic rst,
    // cpu write
    input  logic cpu_wreq_i,
    input  logic [ADDR_WIDTH-1:0] cpu_awaddr_i,
    input  dcache_line_u cpu_wdata_i,
    output logic write_hit_o,
    // cpu read
    input  logic cpu_rreq_i,
    input  logic [ADDR_WIDTH-1:0] cpu_araddr_i,
    output logic read_hit_o,
    output dcache_line_u cpu_rdata_o,
    // queue status
    output logic full_o,
    output logic empty_o,
    // head line toward the engine
    wb_line_if.fifo_mp wb
);

    localparam int IDX_W = $clog2(DEPTH);
    localparam int TAG_W = ADDR_WIDTH - OFFSET_BITS;
    localparam int HIT_PORT = 0;
    localparam int HEAD_PORT = 1;

    // queue pointers and per-entry state
    logic [IDX_W-1:0] head_q;
    logic [IDX_W-1:0] tail_q;
    logic [DEPTH-1:0] valid_q;
    logic [DEPTH-1:0][TAG_W-1:0] tag_q;

    // address match against valid entries
    logic [TAG_W-1:0] aw_tag;
    logic [TAG_W-1:0] ar_tag;
    logic [DEPTH-1:0] aw_match;
    logic [DEPTH-1:0] ar_match;
    logic [IDX_W-1:0] aw_idx;

    logic alloc;
    logic pop;
    logic write_hit_head;
    logic hold_q;

    // registered line write into the ram
    logic ram_we_q;
    logic [IDX_W-1:0] ram_waddr_q;
    dcache_line_u ram_wdata_q;

    // read hit, one cycle behind the request
    logic [DEPTH-1:0] rd_hit_q;
    logic [IDX_W-1:0] rd_idx;

    logic [1:0][IDX_W-1:0] ram_raddr;
    logic [1:0][LINE_WIDTH-1:0] ram_rdata;
    logic head_fwd;
    dcache_line_u head_line;

    // lowest set bit wins, only one is ever set
    function automatic logic [IDX_W-1:0] onehot_to_idx(input logic [DEPTH-1:0] vec);
        logic [IDX_W-1:0] idx;
        idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = IDX_W'(i);
            end
        end
        return idx;
    endfunction

    assign aw_tag = cpu_awaddr_i[ADDR_WIDTH-1:OFFSET_BITS];
    assign ar_tag = cpu_araddr_i[ADDR_WIDTH-1:OFFSET_BITS];

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            aw_match[i] = valid_q[i] && (tag_q[i] == aw_tag);
            ar_match[i] = valid_q[i] && (tag_q[i] == ar_tag);
        end
    end

    assign aw_idx = onehot_to_idx(aw_match);
    assign write_hit_o = cpu_wreq_i && (|aw_match);
    assign write_hit_head = cpu_wreq_i && aw_match[head_q];
    assign alloc = cpu_wreq_i && !(|aw_match);

    assign full_o = valid_q[tail_q];
    assign empty_o = !valid_q[head_q];

    // hold off the head while its rewrite is still on the way to the ram
    assign pop = wb.idle && valid_q[head_q] && !write_hit_head && !hold_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            hold_q <= 1'b0;
        end else if (write_hit_head) begin
            hold_q <= 1'b1;
        end else if (wb.idle) begin
            hold_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q <= '0;
            tail_q <= '0;
            valid_q <= '0;
        end else begin
            if (alloc) begin
                tail_q <= tail_q + IDX_W'(1);
                valid_q[tail_q] <= 1'b1;
            end
            if (pop) begin
                head_q <= head_q + IDX_W'(1);
                valid_q[head_q] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            tag_q[tail_q] <= aw_tag;
        end
    end

    // miss goes to the tail, hit overwrites the matching entry
    always_ff @(posedge clk) begin
        if (rst) begin
            ram_we_q <= 1'b0;
        end else begin
            ram_we_q <= cpu_wreq_i;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_wreq_i) begin
            ram_waddr_q <= write_hit_o ? aw_idx : tail_q;
            ram_wdata_q <= cpu_wdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_hit_q <= '0;
        end else begin
            rd_hit_q <= cpu_rreq_i ? ar_match : '0;
        end
    end

    assign rd_idx = onehot_to_idx(rd_hit_q);
    assign read_hit_o = |rd_hit_q;

    assign ram_raddr[HIT_PORT] = rd_idx;
    assign ram_raddr[HEAD_PORT] = head_q;

    lutram_1w_mr #(
        .WIDTH(LINE_WIDTH),
        .DEPTH(DEPTH),
        .NUM_READ_PORTS(2)
    ) u_line_ram (
        .clk(clk),
        .we_i(ram_we_q),
        .waddr_i(ram_waddr_q),
        .wdata_i(ram_wdata_q.flat),
        .raddr_i(ram_raddr),
        .rdata_o(ram_rdata)
    );

    assign cpu_rdata_o.flat = ram_rdata[HIT_PORT];

    // a freshly allocated head has its line still in the write register
    assign head_fwd = ram_we_q && (ram_waddr_q == head_q);
    assign head_line.flat = head_fwd ? ram_wdata_q.flat : ram_rdata[HEAD_PORT];

    assign wb.wen = pop;
    assign wb.awaddr = {tag_q[head_q], {OFFSET_BITS{1'b0}}};
    assign wb.wdata = head_line;

    // cpu may only write a queued line while the buffer is full
    a_no_miss_when_full: assert property (
        @(posedge clk) disable iff (rst) cpu_wreq_i && full_o |-> write_hit_o
    ) else $error("write miss while buffer full");

    // handoff only to an idle engine, which then goes busy
    a_wen_idle: assert property (
        @(posedge clk) disable iff (rst) wb.wen |-> wb.idle ##1 !wb.idle
    ) else $error("line handed to busy engine");

    // tags of valid entries stay unique
    a_single_match: assert property (
        @(posedge clk) disable iff (rst) $onehot0(aw_match) && $onehot0(ar_match)
    ) else $error("address matches more than one entry");

endmodule

`default_nettype wire

// File: logic/lutram_1w_mr.sv
`timescale 1ns/100ps
`default_nettype none

module lutram_1w_mr #(
    parameter int WIDTH = 128,
    parameter int DEPTH = 4,
    parameter int NUM_READ_PORTS = 2
) (
    input  logic clk,
    // write port
    input  logic we_i,
    input  logic [$clog2(DEPTH)-1:0] waddr_i,
    input  logic [WIDTH-1:0] wdata_i,
    // read ports, combinational
    input  logic [NUM_READ_PORTS-1:0][$clog2(DEPTH)-1:0] raddr_i,
    output logic [NUM_READ_PORTS-1:0][WIDTH-1:0] rdata_o
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // every read port sees the array directly
    always_comb begin
        for (int p = 0; p < NUM_READ_PORTS; p++) begin
            rdata_o[p] = mem[raddr_i[p]];
        end
    end

endmodule

`default_nettype wire

// File: logic/wb_line_if.sv
`timescale 1ns/100ps
`default_nettype none

interface wb_line_if
    import wbuf_pkg::*;
();

    // head line offered by the buffer
    logic wen;
    logic [ADDR_WIDTH-1:0] awaddr;
    dcache_line_u wdata;

    // engine has no line in flight
    logic idle;

    modport fifo_mp (
        output wen,
        output awaddr,
        output wdata,
        input  idle
    );

    modport engine_mp (
        input  wen,
        input  awaddr,
        input  wdata,
        output idle
    );

endinterface

`default_nettype wire

// File: logic/wbuf_pkg.sv
`default_nettype none

package wbuf_pkg;

    // byte address and data widths
    localparam int ADDR_WIDTH = 32;
    localparam int LINE_WIDTH = 128;
    localparam int WORD_WIDTH = 32;

    // memory beats that make up one line
    localparam int WORDS_PER_LINE = LINE_WIDTH / WORD_WIDTH;

    // byte-in-line bits, ignored on match and zero on output
    localparam int OFFSET_BITS = $clog2(LINE_WIDTH / 8);

    // one cache line, either flat or as memory words
    typedef union packed {
        logic [LINE_WIDTH-1:0] flat;
        logic [WORDS_PER_LINE-1:0][WORD_WIDTH-1:0] words;
    } dcache_line_u;

endpackage

`default_nettype wire
